//--- files.f
hdl/fetch_pkg.sv
hdl/isa_pkg.sv
hdl/pc_stage.sv
hdl/icache_stage.sv
hdl/predecode_stage.sv
hdl/fetch_top.sv
verif/clk_gen.sv
verif/tb_mem.sv
verif/fetch_tb.sv

//--- hdl/fetch_pkg.sv
package fetch_pkg;

  // Fetch address width.
  localparam int PC_W = 32;

  // ----------------------------------------
  // L1 instruction cache geometry
  // ----------------------------------------
  localparam int ICACHE_SETS  = 4;
  localparam int ICACHE_WORDS = 2;

  // PC splits into {tag, index, word offset, byte offset}.
  localparam int IDX_W = 2;
  localparam int OFS_W = 1;
  localparam int TAG_W = 27;

  localparam int OFS_LSB = 2;
  localparam int IDX_LSB = OFS_LSB + OFS_W;
  localparam int TAG_LSB = IDX_LSB + IDX_W;

  localparam logic [PC_W-1:0] PC_INIT = 32'h8000_0000;

  // Refill sequencer, one request and one wait per word.
  typedef enum logic [2:0] {
    IDLE,
    REQ0,
    WAIT0,
    REQ1,
    WAIT1
  } icache_state_e;

endpackage

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_valid_i,
  input  logic [PC_W-1:0] redirect_pc_i,
  input  logic            ready_i,
  output logic            valid_o,
  output logic [PC_W-1:0] pc_o,
  output logic [31:0]     inst_o,
  output logic            ctrl_o,
  output logic            mem_arvalid_o,
  output logic [PC_W-1:0] mem_araddr_o,
  input  logic            mem_rvalid_i,
  input  logic [31:0]     mem_rdata_i
);

  // PC stage to cache.
  logic            req_valid;
  logic            req_ready;
  logic [PC_W-1:0] req_pc;

  // Cache to predecode.
  logic            ic_valid;
  logic            ic_ready;
  logic [PC_W-1:0] ic_pc;
  logic [31:0]     ic_inst;

  logic            flush_inv;

  pc_stage i_pc_stage (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_ready_i      (req_ready),
    .req_valid_o      (req_valid),
    .req_pc_o         (req_pc)
  );

  icache_stage i_icache_stage (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .flush_inv_i      (flush_inv),
    .req_valid_i      (req_valid),
    .req_pc_i         (req_pc),
    .req_ready_o      (req_ready),
    .mem_arvalid_o    (mem_arvalid_o),
    .mem_araddr_o     (mem_araddr_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .ic_ready_i       (ic_ready),
    .ic_valid_o       (ic_valid),
    .ic_pc_o          (ic_pc),
    .ic_inst_o        (ic_inst)
  );

  predecode_stage i_predecode_stage (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .ic_valid_i       (ic_valid),
    .ic_pc_i          (ic_pc),
    .ic_inst_i        (ic_inst),
    .ready_i          (ready_i),
    .ic_ready_o       (ic_ready),
    .valid_o          (valid_o),
    .pc_o             (pc_o),
    .inst_o           (inst_o),
    .ctrl_o           (ctrl_o),
    .flush_inv_o      (flush_inv)
  );

endmodule

//--- hdl/icache_stage.sv
`timescale 1ns/1ps

module icache_stage
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_valid_i,
  input  logic            flush_inv_i,
  input  logic            req_valid_i,
  input  logic [PC_W-1:0] req_pc_i,
  output logic            req_ready_o,
  output logic            mem_arvalid_o,
  output logic [PC_W-1:0] mem_araddr_o,
  input  logic            mem_rvalid_i,
  input  logic [31:0]     mem_rdata_i,
  input  logic            ic_ready_i,
  output logic            ic_valid_o,
  output logic [PC_W-1:0] ic_pc_o,
  output logic [31:0]     ic_inst_o
);

  // ----------------------------------------
  // Arrays
  // ----------------------------------------
  logic [31:0]            data_q [ICACHE_SETS][ICACHE_WORDS];
  logic [TAG_W-1:0]       tag_q  [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] valid_q;

  // Held request.
  logic            hold_q;
  logic [PC_W-1:0] pc_q;

  // Refill in progress.
  icache_state_e    state_q;
  logic [TAG_W-1:0] fill_tag_q;
  logic [IDX_W-1:0] fill_idx_q;
  logic             fill_kill_q;

  logic [TAG_W-1:0] req_tag;
  logic [IDX_W-1:0] req_idx;
  logic [OFS_W-1:0] req_ofs;
  logic             hit;
  logic             accept;
  logic             start_fill;
  logic             fill_done;

  assign req_tag = pc_q[TAG_LSB +: TAG_W];
  assign req_idx = pc_q[IDX_LSB +: IDX_W];
  assign req_ofs = pc_q[OFS_LSB +: OFS_W];

  // Lookups only count while no refill is rewriting the arrays.
  assign hit = (state_q == IDLE) && valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  assign ic_valid_o = hold_q && hit;
  assign ic_pc_o    = pc_q;
  assign ic_inst_o  = data_q[req_idx][req_ofs];

  assign req_ready_o = !hold_q || (ic_valid_o && ic_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  assign start_fill = (state_q == IDLE) && hold_q && !hit && !redirect_valid_i;
  assign fill_done  = (state_q == WAIT1) && mem_rvalid_i;

  // Line base first, then the second word.
  assign mem_arvalid_o = (state_q == REQ0) || (state_q == REQ1);
  assign mem_araddr_o  = {fill_tag_q, fill_idx_q, OFS_W'(state_q == REQ1), 2'b00};

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hold_q <= 1'b0;
    end
    else if (redirect_valid_i)
    begin
      hold_q <= 1'b0;
    end
    else if (req_ready_o)
    begin
      hold_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pc_q <= req_pc_i;
    end
  end

  // ----------------------------------------
  // Refill FSM
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (start_fill)
          begin
            state_q <= REQ0;
          end
        end
        REQ0:
        begin
          state_q <= WAIT0;
        end
        WAIT0:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= REQ1;
          end
        end
        REQ1:
        begin
          state_q <= WAIT1;
        end
        WAIT1:
        begin
          if (mem_rvalid_i)
          begin
            state_q <= IDLE;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // The line address survives a redirect, so the refill can finish.
  always_ff @(posedge clk)
  begin
    if (start_fill)
    begin
      fill_tag_q <= req_tag;
      fill_idx_q <= req_idx;
    end
  end

  // A flush seen during the refill leaves the new line invalid.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fill_kill_q <= 1'b0;
    end
    else if (start_fill)
    begin
      fill_kill_q <= flush_inv_i;
    end
    else if (flush_inv_i)
    begin
      fill_kill_q <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == WAIT0) && mem_rvalid_i)
    begin
      data_q[fill_idx_q][0] <= mem_rdata_i;
    end
    if (fill_done)
    begin
      data_q[fill_idx_q][1] <= mem_rdata_i;
    end
    if (start_fill)
    begin
      tag_q[req_idx] <= req_tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (flush_inv_i)
    begin
      valid_q <= '0;
    end
    else if (start_fill)
    begin
      valid_q[req_idx] <= 1'b0;
    end
    else if (fill_done && !fill_kill_q)
    begin
      valid_q[fill_idx_q] <= 1'b1;
    end
  end

endmodule

//--- hdl/isa_pkg.sv
package isa_pkg;

  // ----------------------------------------
  // RV32 major opcodes
  // ----------------------------------------
  // Instruction bits [6:0].
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_IMM      = 7'b0010011,
    OP_REG      = 7'b0110011,
    OP_MISC_MEM = 7'b0001111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // ----------------------------------------
  // Special encodings
  // ----------------------------------------
  // FENCE.I with rd, rs1 and imm all zero.
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

endpackage

//--- hdl/pc_stage.sv
`timescale 1ns/1ps

module pc_stage
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_valid_i,
  input  logic [PC_W-1:0] redirect_pc_i,
  input  logic            req_ready_i,
  output logic            req_valid_o,
  output logic [PC_W-1:0] req_pc_o
);

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_seq;
  logic            valid_q;
  logic            fire;

  // The PC is always on offer, except while a redirect replaces it.
  assign req_valid_o = valid_q && !redirect_valid_i;
  assign req_pc_o    = pc_q;

  assign fire   = req_valid_o && req_ready_i;
  assign pc_seq = pc_q + 32'd4;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1;
    end
  end

  // Redirect wins over the sequential step.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= PC_INIT;
    end
    else if (redirect_valid_i)
    begin
      pc_q <= redirect_pc_i;
    end
    else if (fire)
    begin
      pc_q <= pc_seq;
    end
  end

endmodule

//--- hdl/predecode_stage.sv
`timescale 1ns/1ps

module predecode_stage
  import isa_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect_valid_i,
  input  logic        ic_valid_i,
  input  logic [31:0] ic_pc_i,
  input  logic [31:0] ic_inst_i,
  input  logic        ready_i,
  output logic        ic_ready_o,
  output logic        valid_o,
  output logic [31:0] pc_o,
  output logic [31:0] inst_o,
  output logic        ctrl_o,
  output logic        flush_inv_o
);

  opcode_e     opcode;
  logic        is_fence_i;
  logic        is_ctrl;
  logic        take;
  logic        valid_q;
  logic        squash_q;
  logic        flush_q;
  logic        ctrl_q;
  logic [31:0] pc_q;
  logic [31:0] inst_q;

  assign opcode     = opcode_e'(ic_inst_i[6:0]);
  assign is_fence_i = (ic_inst_i == INST_FENCE_I);

  always_comb
  begin
    case (opcode)
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: is_ctrl = 1'b1;
      default: is_ctrl = is_fence_i;
    endcase
  end

  // Wrong-path words are swallowed while squashed.
  assign ic_ready_o = squash_q || !valid_q || ready_i;
  assign take       = ic_valid_i && ic_ready_o && !squash_q && !redirect_valid_i;

  assign valid_o     = valid_q;
  assign pc_o        = pc_q;
  assign inst_o      = inst_q;
  assign ctrl_o      = ctrl_q;
  assign flush_inv_o = flush_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q  <= 1'b0;
      squash_q <= 1'b0;
      flush_q  <= 1'b0;
    end
    else
    begin
      if (take)
        valid_q <= 1'b1;
      else if (ready_i)
        valid_q <= 1'b0;

      if (redirect_valid_i)
        squash_q <= 1'b0;
      else if (take && is_ctrl)
        squash_q <= 1'b1;

      flush_q <= take && is_fence_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      pc_q   <= ic_pc_i;
      inst_q <= ic_inst_i;
      ctrl_q <= is_ctrl;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module fetch_tb \
  -f files.f \
  -o fetch_sim

# The pipeline status is the status of grep.
./obj_dir/fetch_sim | tee /dev/stderr | grep -q "^PASS: all tests$"

echo "simulation passed"

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
(
  output logic clk_o,
  output logic rst_o
);

  // 8 ns period.
  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset is held for 10 cycles and released on a falling edge.
  initial
  begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
  import isa_pkg::*;
();

  localparam int RESET_CYCLES    = 10;
  localparam int PLANNED_FETCHES = 28;

  logic        clk;
  logic        rst;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        ready;
  logic        valid;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        ctrl;
  logic        arvalid;
  logic [31:0] araddr;
  logic        rvalid;
  logic [31:0] rdata;
  int          read_count;

  // Scoreboard state.
  logic [31:0] exp_pc;
  logic        wait_redir;
  logic [31:0] exp_inst;
  logic        exp_ctrl;
  logic [31:0] first_reads [2];
  logic [28:0] watch_line;
  int          out_count;
  int          reads_seen;
  int          watch_reads;
  int          mon_errors;
  int          main_errors;
  int          sva_errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          mark;

  clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  tb_mem i_mem (
    .clk          (clk),
    .arvalid_i    (arvalid),
    .araddr_i     (araddr),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .read_count_o (read_count)
  );

  fetch_top i_fetch_top (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .ready_i          (ready),
    .valid_o          (valid),
    .pc_o             (pc),
    .inst_o           (inst),
    .ctrl_o           (ctrl),
    .mem_arvalid_o    (arvalid),
    .mem_araddr_o     (araddr),
    .mem_rvalid_i     (rvalid),
    .mem_rdata_i      (rdata)
  );

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Control transfers and FENCE.I stop the fetch.
  function automatic logic expect_ctrl(input logic [31:0] w);
    logic c;
    case (w[6:0])
      OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: c = 1'b1;
      default: c = (w == INST_FENCE_I);
    endcase
    return c;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], OP_IMM};
  endfunction

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  initial
  begin
    logic [31:0] seed;
    seed  = 32'ha3085a59;
    ready = 1'b1;
    forever
    begin
      @(negedge clk);
      seed  = next_rand(seed);
      ready = (seed[31:30] != 2'b00);
    end
  end

  task automatic place_word(input logic [31:0] addr, input logic [31:0] w);
    i_mem.mem[addr[9:2]] = w;
  endtask

  task automatic redirect_to(input logic [31:0] target);
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_pc    = target;
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  task automatic wait_stop();
    while (!wait_redir)
      @(posedge clk);
    @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name);
    int now;
    now = mon_errors + main_errors + sva_errors;
    tests_run = tests_run + 1;
    if (now == err_mark)
      $display("test %0d %s: ok", num, name);
    else
    begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d errors", num, name, now - err_mark);
    end
    err_mark = now;
  endtask

  // ----------------------------------------
  // Output monitor and scoreboard
  // ----------------------------------------
  initial
  begin
    exp_pc      = PC_INIT;
    wait_redir  = 1'b0;
    out_count   = 0;
    reads_seen  = 0;
    watch_reads = 0;
    mon_errors  = 0;
  end

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (arvalid)
      begin
        if (reads_seen < 2)
          first_reads[reads_seen] = araddr;
        reads_seen = reads_seen + 1;
        if (araddr[31:3] == watch_line)
          watch_reads = watch_reads + 1;
      end
      if (valid && ready)
      begin
        exp_inst = i_mem.mem[exp_pc[9:2]];
        exp_ctrl = expect_ctrl(exp_inst);
        assert (pc == exp_pc)
        else
        begin
          mon_errors = mon_errors + 1;
          $display("FAILED pc_o: got %h expected %h", pc, exp_pc);
        end
        assert (inst == exp_inst)
        else
        begin
          mon_errors = mon_errors + 1;
          $display("FAILED inst_o at %h: got %h expected %h", exp_pc, inst, exp_inst);
        end
        assert (ctrl == exp_ctrl)
        else
        begin
          mon_errors = mon_errors + 1;
          $display("FAILED ctrl_o at %h: got %h expected %h", exp_pc, ctrl, exp_ctrl);
        end
        out_count = out_count + 1;
        if (exp_ctrl)
          wait_redir <= 1'b1;
        else
          exp_pc <= exp_pc + 32'd4;
      end
      if (redirect_valid)
      begin
        exp_pc     <= redirect_pc;
        wait_redir <= 1'b0;
      end
    end
  end

  // Nothing comes out between a control word and its redirect.
  assert property (@(posedge clk) disable iff (rst) wait_redir |-> !valid)
  else
  begin
    sva_errors = sva_errors + 1;
    $display("valid_o rose after a control word before any redirect");
  end

  // Back-pressure holds the output item.
  assert property (@(posedge clk) disable iff (rst)
                   (valid && !ready) |=> (valid && $stable(pc) && $stable(inst)))
  else
  begin
    sva_errors = sva_errors + 1;
    $display("output item changed while ready_i was low");
  end

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial
  begin
    repeat (RESET_CYCLES + PLANNED_FETCHES * 16) @(posedge clk);
    $display("timeout: fetch did not finish the planned words in time");
    $display("FAIL: see errors above");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    redirect_valid = 1'b0;
    redirect_pc    = 32'd0;
    watch_line     = '1;
    main_errors    = 0;
    sva_errors     = 0;
    err_mark       = 0;
    tests_run      = 0;
    tests_failed   = 0;
    for (int i = 0; i < 256; i++)
      i_mem.mem[i] = fill_word(PC_INIT + 32'(i * 4));
    place_word(PC_INIT + 32'h02c, {25'd0, OP_JAL});
    place_word(PC_INIT + 32'h10c, {25'd0, OP_BRANCH});
    place_word(PC_INIT + 32'h204, {25'd0, OP_SYSTEM});
    place_word(PC_INIT + 32'h304, INST_FENCE_I);
    place_word(PC_INIT + 32'h38c, {20'h00008, 5'd0, OP_JALR});

    while (rst)
      @(negedge clk);
    assert (!valid && !arvalid)
    else
    begin
      main_errors = main_errors + 1;
      $display("valid_o or mem_arvalid_o high right after reset");
    end
    while (reads_seen < 2)
      @(posedge clk);
    @(negedge clk);
    assert (first_reads[0] == PC_INIT)
    else
    begin
      main_errors = main_errors + 1;
      $display("FAILED mem_araddr_o: got %h expected %h", first_reads[0], PC_INIT);
    end
    assert (first_reads[1] == PC_INIT + 32'd4)
    else
    begin
      main_errors = main_errors + 1;
      $display("FAILED mem_araddr_o: got %h expected %h", first_reads[1], PC_INIT + 32'd4);
    end
    report_test(1, "reset and first refill");

    wait_stop();
    assert (out_count == 12)
    else
    begin
      main_errors = main_errors + 1;
      $display("sequential run gave %0d words instead of 12", out_count);
    end
    report_test(2, "sequential run");

    repeat (20) @(negedge clk);
    redirect_to(PC_INIT + 32'h100);
    wait_stop();
    repeat (20) @(negedge clk);
    redirect_to(PC_INIT + 32'h200);
    wait_stop();
    report_test(3, "stop after control word");

    // Return to the line at 0x200 while it is still cached.
    repeat (2) @(negedge clk);
    watch_line = PC_INIT[31:3] + 29'h40;
    mark       = watch_reads;
    redirect_to(PC_INIT + 32'h200);
    wait_stop();
    assert (watch_reads == mark)
    else
    begin
      main_errors = main_errors + 1;
      $display("cached line was read from the bus again");
    end
    report_test(4, "redirect to cached line");

    watch_line = PC_INIT[31:3] + 29'h60;
    redirect_to(PC_INIT + 32'h300);
    wait_stop();
    mark = watch_reads;
    place_word(PC_INIT + 32'h300, {20'h12345, 5'd2, OP_IMM});
    redirect_to(PC_INIT + 32'h300);
    wait_stop();
    assert (watch_reads == mark + 2)
    else
    begin
      main_errors = main_errors + 1;
      $display("FENCE.I did not force a refill of the line");
    end
    report_test(5, "fence.i invalidation");

    // Wrong-path refill in flight when the redirect lands.
    while (!arvalid)
      @(negedge clk);
    redirect_to(PC_INIT + 32'h380);
    wait_stop();
    assert (out_count == PLANNED_FETCHES)
    else
    begin
      main_errors = main_errors + 1;
      $display("saw %0d words instead of %0d", out_count, PLANNED_FETCHES);
    end
    report_test(6, "redirect during miss");

    $display("tests %0d, failed %0d, errors %0d, bus reads %0d",
             tests_run, tests_failed, mon_errors + main_errors + sva_errors, read_count);
    if (tests_failed == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verif/tb_mem.sv
`timescale 1ns/1ps

module tb_mem
(
  input  logic        clk,
  input  logic        arvalid_i,
  input  logic [31:0] araddr_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output int          read_count_o
);

  // Word array, indexed by address bits [9:2].
  logic [31:0] mem [256];

  logic [31:0] seed;
  logic        busy;
  logic [31:0] addr_q;
  logic [31:0] delay;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One read at a time, answered 1 to 4 cycles after the request.
  initial
  begin
    rvalid_o     = 1'b0;
    rdata_o      = 32'd0;
    read_count_o = 0;
    seed         = 32'ha3085a59;
    busy         = 1'b0;
    addr_q       = 32'd0;
    delay        = 32'd0;
    forever
    begin
      @(negedge clk);
      rvalid_o = 1'b0;
      if (busy)
      begin
        if (delay == 32'd0)
        begin
          rvalid_o = 1'b1;
          rdata_o  = mem[addr_q[9:2]];
          busy     = 1'b0;
        end
        else
        begin
          delay = delay - 32'd1;
        end
      end
      if (arvalid_i)
      begin
        seed         = next_rand(seed);
        busy         = 1'b1;
        addr_q       = araddr_i;
        delay        = {30'd0, seed[17:16]};
        read_count_o = read_count_o + 1;
      end
    end
  end

endmodule
